// ==== Makefile ====
# Verilator build and run of the ALU fault monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_alu_fault_monitor
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard source/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(BUILD_DIR)

// ==== source/alu_fault_consts.svh ====
/*
  ALU fault monitor constants
  Sizes, policy defaults, sub-unit indices, config selects, ALU opcodes
*/
`ifndef ALU_FAULT_CONSTS_SVH
`define ALU_FAULT_CONSTS_SVH

// Sizes
`define NUM_ALU           4
`define NUM_SUBUNIT       9
`define ALU_OP_W          7
`define CNT_W             8
`define STEP_W            2

// Policy values loaded at reset
`define DEF_THRESHOLD     8'd8
`define DEF_INCREASE      2'd2
`define DEF_DECREASE      2'd1

// Sub-unit class indices
`define SU_SHIFT          0
`define SU_LOGIC          1
`define SU_BITMAN         2
`define SU_BITCNT         3
`define SU_SHUFFLE        4
`define SU_COMPARE        5
`define SU_ABSCLIP        6
`define SU_MINMAX         7
`define SU_DIVREM         8

// Policy register selects, 3 is unused
`define CFG_SEL_THRESHOLD 2'd0
`define CFG_SEL_INCREASE  2'd1
`define CFG_SEL_DECREASE  2'd2

//////////////////////////////////////////////////
// cv32e40p ALU opcodes
//////////////////////////////////////////////////

// Adder and shifter
`define ALU_ADD           7'b0011000
`define ALU_SUB           7'b0011001
`define ALU_ADDU          7'b0011010
`define ALU_SUBU          7'b0011011
`define ALU_ADDR          7'b0011100
`define ALU_SUBR          7'b0011101
`define ALU_ADDUR         7'b0011110
`define ALU_SUBUR         7'b0011111
`define ALU_SRA           7'b0100100
`define ALU_SRL           7'b0100101
`define ALU_ROR           7'b0100110
`define ALU_SLL           7'b0100111

// Logic
`define ALU_XOR           7'b0101111
`define ALU_OR            7'b0101110
`define ALU_AND           7'b0010101

// Bit manipulation
`define ALU_BEXT          7'b0101000
`define ALU_BEXTU         7'b0101001
`define ALU_BINS          7'b0101010
`define ALU_BCLR          7'b0101011
`define ALU_BSET          7'b0101100
`define ALU_BREV          7'b1001001

// Bit counting
`define ALU_FF1           7'b0110110
`define ALU_FL1           7'b0110111
`define ALU_CNT           7'b0110100
`define ALU_CLB           7'b0110101

// Shuffle and extension
`define ALU_EXTS          7'b0111110
`define ALU_EXT           7'b0111111
`define ALU_SHUF          7'b0111010
`define ALU_SHUF2         7'b0111011
`define ALU_PCKLO         7'b0111000
`define ALU_PCKHI         7'b0111001
`define ALU_INS           7'b0101101

// Comparison
`define ALU_LTS           7'b0000000
`define ALU_LTU           7'b0000001
`define ALU_LES           7'b0000100
`define ALU_LEU           7'b0000101
`define ALU_GTS           7'b0001000
`define ALU_GTU           7'b0001001
`define ALU_GES           7'b0001010
`define ALU_GEU           7'b0001011
`define ALU_EQ            7'b0001100
`define ALU_NE            7'b0001101
`define ALU_SLTS          7'b0000010
`define ALU_SLTU          7'b0000011
`define ALU_SLETS         7'b0000110
`define ALU_SLETU         7'b0000111

// Absolute value and clip
`define ALU_ABS           7'b0010100
`define ALU_CLIP          7'b0010110
`define ALU_CLIPU         7'b0010111

// Min and max
`define ALU_MIN           7'b0010000
`define ALU_MINU          7'b0010010
`define ALU_MAX           7'b0010001
`define ALU_MAXU          7'b0010011

// Divider
`define ALU_DIVU          7'b0110000
`define ALU_DIV           7'b0110001
`define ALU_REMU          7'b0110010
`define ALU_REM           7'b0110011

`endif

// ==== source/alu_fault_monitor.sv ====
/*
  ALU permanent-fault monitor
  Four ALUs, nine leaky counters each, shared policy registers
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_fault_consts.svh"

module alu_fault_monitor (
  input  logic                                     clock_gated,
  input  logic                                     rst_n,
  input  logic [`NUM_ALU-1:0]                      alu_enable_i,
  input  alu_fault_pkg::alu_op_t [`NUM_ALU-1:0]    alu_operator_i,
  input  logic [`NUM_ALU-1:0]                      error_detected_i,
  input  logic                                     div_ready_i,
  input  logic                                     cfg_we_i,
  input  alu_fault_pkg::cfg_sel_t                  cfg_sel_i,
  input  alu_fault_pkg::fault_cnt_t                cfg_data_i,
  output alu_fault_pkg::subunit_vec_t [`NUM_ALU-1:0] fault_flags_o,
  output logic [`NUM_ALU-1:0]                      perf_fault_o
);
  import alu_fault_pkg::*;

  fault_cnt_t threshold;
  err_step_t  increase;
  err_step_t  decrease;

  // One policy set shared by all ALUs
  fault_policy_regs u_policy (
    .clock_gated (clock_gated),
    .rst_n       (rst_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_sel_i   (cfg_sel_i),
    .cfg_data_i  (cfg_data_i),
    .threshold_o (threshold),
    .increase_o  (increase),
    .decrease_o  (decrease)
  );

  for (genvar g = 0; g < `NUM_ALU; g++) begin : gen_alu
    class_event_if ev ();

    alu_op_classifier u_classifier (
      .alu_enable_i     (alu_enable_i[g]),
      .alu_operator_i   (alu_operator_i[g]),
      .error_detected_i (error_detected_i[g]),
      .div_ready_i      (div_ready_i),
      .ev               (ev)
    );

    subunit_fault_counters u_counters (
      .clock_gated   (clock_gated),
      .rst_n         (rst_n),
      .threshold_i   (threshold),
      .increase_i    (increase),
      .decrease_i    (decrease),
      .ev            (ev),
      .fault_flags_o (fault_flags_o[g]),
      .perf_fault_o  (perf_fault_o[g])
    );
  end

endmodule

`default_nettype wire

// ==== source/alu_fault_pkg.sv ====
/*
  ALU fault monitor types
*/
`default_nettype none

`include "alu_fault_consts.svh"

package alu_fault_pkg;

  // One ALU opcode
  typedef logic [`ALU_OP_W-1:0]    alu_op_t;

  // One bit per sub-unit class, used for the class and for the flags
  typedef logic [`NUM_SUBUNIT-1:0] subunit_vec_t;

  // Leaky counter value, also the threshold
  typedef logic [`CNT_W-1:0]       fault_cnt_t;

  // Counter step on error or on a clean operation
  typedef logic [`STEP_W-1:0]      err_step_t;

  // Policy register select
  typedef logic [1:0]              cfg_sel_t;

endpackage

`default_nettype wire

// ==== source/alu_op_classifier.sv ====
/*
  Opcode classifier for one ALU
  Maps the opcode to its sub-unit class and qualifies the counter update
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_fault_consts.svh"

module alu_op_classifier (
  input  logic                   alu_enable_i,
  input  alu_fault_pkg::alu_op_t alu_operator_i,
  input  logic                   error_detected_i,
  input  logic                   div_ready_i,
  class_event_if.classifier      ev
);
  import alu_fault_pkg::*;

  subunit_vec_t cls;
  logic         known_op;

  always_comb begin
    cls      = '0;
    known_op = 1'b1;
    case (alu_operator_i)
      `ALU_ADD, `ALU_SUB, `ALU_ADDU, `ALU_SUBU, `ALU_ADDR, `ALU_SUBR,
      `ALU_ADDUR, `ALU_SUBUR, `ALU_SRA, `ALU_SRL, `ALU_ROR, `ALU_SLL:
        cls[`SU_SHIFT] = 1'b1;
      `ALU_XOR, `ALU_OR, `ALU_AND:
        cls[`SU_LOGIC] = 1'b1;
      `ALU_BEXT, `ALU_BEXTU, `ALU_BINS, `ALU_BCLR, `ALU_BSET, `ALU_BREV:
        cls[`SU_BITMAN] = 1'b1;
      `ALU_FF1, `ALU_FL1, `ALU_CNT, `ALU_CLB:
        cls[`SU_BITCNT] = 1'b1;
      `ALU_EXTS, `ALU_EXT, `ALU_SHUF, `ALU_SHUF2, `ALU_PCKLO, `ALU_PCKHI, `ALU_INS:
        cls[`SU_SHUFFLE] = 1'b1;
      `ALU_LTS, `ALU_LTU, `ALU_LES, `ALU_LEU, `ALU_GTS, `ALU_GTU, `ALU_GES,
      `ALU_GEU, `ALU_EQ, `ALU_NE, `ALU_SLTS, `ALU_SLTU, `ALU_SLETS, `ALU_SLETU:
        cls[`SU_COMPARE] = 1'b1;
      `ALU_ABS, `ALU_CLIP, `ALU_CLIPU:
        cls[`SU_ABSCLIP] = 1'b1;
      `ALU_MIN, `ALU_MINU, `ALU_MAX, `ALU_MAXU:
        cls[`SU_MINMAX] = 1'b1;
      `ALU_DIVU, `ALU_DIV, `ALU_REMU, `ALU_REM:
        cls[`SU_DIVREM] = 1'b1;
      default:
        known_op = 1'b0;
    endcase
  end

  assign ev.cls       = cls;
  // Multi-cycle divide only counts once the divider has a result
  assign ev.upd_en    = alu_enable_i & ~(cls[`SU_DIVREM] & ~div_ready_i);
  assign ev.clear_all = alu_enable_i & ~known_op;
  assign ev.err       = error_detected_i;

endmodule

`default_nettype wire

// ==== source/class_event_if.sv ====
/*
  Classified operation of one ALU, from the opcode decoder to its counter bank
*/
`timescale 1ns/1ps
`default_nettype none

interface class_event_if;
  import alu_fault_pkg::*;

  logic         upd_en;
  subunit_vec_t cls;
  logic         clear_all;
  logic         err;

  modport classifier (output upd_en, output cls, output clear_all, output err);
  modport counters   (input upd_en, input cls, input clear_all, input err);

endinterface

`default_nettype wire

// ==== source/fault_policy_regs.sv ====
/*
  Fault policy registers
  Threshold and counter steps, defaults at reset, written by a strobe
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_fault_consts.svh"

module fault_policy_regs (
  input  logic                      clock_gated,
  input  logic                      rst_n,
  input  logic                      cfg_we_i,
  input  alu_fault_pkg::cfg_sel_t   cfg_sel_i,
  input  alu_fault_pkg::fault_cnt_t cfg_data_i,
  output alu_fault_pkg::fault_cnt_t threshold_o,
  output alu_fault_pkg::err_step_t  increase_o,
  output alu_fault_pkg::err_step_t  decrease_o
);
  import alu_fault_pkg::*;

  fault_cnt_t threshold_q;
  err_step_t  increase_q;
  err_step_t  decrease_q;

  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      threshold_q <= `DEF_THRESHOLD;
      increase_q  <= `DEF_INCREASE;
      decrease_q  <= `DEF_DECREASE;
    end else if (cfg_we_i) begin
      case (cfg_sel_i)
        `CFG_SEL_THRESHOLD: threshold_q <= cfg_data_i;
        // Steps keep only the low bits
        `CFG_SEL_INCREASE:  increase_q  <= cfg_data_i[`STEP_W-1:0];
        `CFG_SEL_DECREASE:  decrease_q  <= cfg_data_i[`STEP_W-1:0];
        default: ;
      endcase
    end
  end

  assign threshold_o = threshold_q;
  assign increase_o  = increase_q;
  assign decrease_o  = decrease_q;

  a_cfg_sel_valid : assert property (@(posedge clock_gated) disable iff (!rst_n)
    cfg_we_i |-> cfg_sel_i inside {`CFG_SEL_THRESHOLD, `CFG_SEL_INCREASE, `CFG_SEL_DECREASE})
    else $error("policy write with unused select %0d", cfg_sel_i);

endmodule

`default_nettype wire

// ==== source/subunit_fault_counters.sv ====
/*
  Leaky error counters for the nine sub-units of one ALU
  Sticky fault flags and a one-cycle perf pulse per newly set flag event
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_fault_consts.svh"

module subunit_fault_counters (
  input  logic                        clock_gated,
  input  logic                        rst_n,
  input  alu_fault_pkg::fault_cnt_t   threshold_i,
  input  alu_fault_pkg::err_step_t    increase_i,
  input  alu_fault_pkg::err_step_t    decrease_i,
  class_event_if.counters             ev,
  output alu_fault_pkg::subunit_vec_t fault_flags_o,
  output logic                        perf_fault_o
);
  import alu_fault_pkg::*;

  fault_cnt_t   cnt_q [`NUM_SUBUNIT];
  fault_cnt_t   cnt_d [`NUM_SUBUNIT];
  subunit_vec_t flags_q;
  subunit_vec_t flag_set;
  logic         set_q;
  logic         perf_q;

  //////////////////////////////////////////////////
  // Next counter values
  //////////////////////////////////////////////////

  always_comb begin
    logic [`CNT_W:0] sum;
    fault_cnt_t      sat;

    flag_set = '0;
    for (int c = 0; c < `NUM_SUBUNIT; c++) begin
      cnt_d[c] = cnt_q[c];
      sum      = {1'b0, cnt_q[c]} + {{(`CNT_W + 1 - `STEP_W){1'b0}}, increase_i};
      sat      = sum[`CNT_W] ? {`CNT_W{1'b1}} : sum[`CNT_W-1:0];
      if (ev.clear_all) begin
        cnt_d[c] = '0;
      end else if (ev.upd_en && ev.cls[c] && !flags_q[c]) begin
        if (ev.err) begin
          // Compare on >= so a large step cannot jump over the threshold
          if (sat >= threshold_i) begin
            flag_set[c] = 1'b1;
            cnt_d[c]    = '0;
          end else begin
            cnt_d[c] = sat;
          end
        end else if (cnt_q[c] > fault_cnt_t'(2)) begin
          cnt_d[c] = cnt_q[c] - {{(`CNT_W - `STEP_W){1'b0}}, decrease_i};
        end else begin
          cnt_d[c] = '0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '{default: '0};
      flags_q <= '0;
      set_q   <= 1'b0;
      perf_q  <= 1'b0;
    end else begin
      cnt_q   <= cnt_d;
      flags_q <= flags_q | flag_set;
      // Perf pulse trails the flag by one more edge
      set_q   <= |flag_set;
      perf_q  <= set_q;
    end
  end

  assign fault_flags_o = flags_q;
  assign perf_fault_o  = perf_q;

  a_flags_sticky : assert property (@(posedge clock_gated) disable iff (!rst_n)
    ($past(flags_q) & ~flags_q) == '0)
    else $error("fault flag cleared, was %b now %b", $past(flags_q), flags_q);

  // Every perf pulse comes from a flag that rose on the edge before
  a_perf_from_flag : assert property (@(posedge clock_gated) disable iff (!rst_n)
    perf_q |-> ($past(flags_q) != $past(flags_q, 2)))
    else $error("perf pulse without a newly set flag");

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/alu_fault_pkg.sv
source/class_event_if.sv
source/fault_policy_regs.sv
source/alu_op_classifier.sv
source/subunit_fault_counters.sv
source/alu_fault_monitor.sv
testbench/tb_clock_gen.sv
testbench/tb_alu_fault_monitor.sv

// ==== testbench/tb_alu_fault_monitor.sv ====
/*
  Testbench for the ALU fault monitor
  Directed tests and random traffic against a cycle model of counters and flags
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_fault_consts.svh"

module tb_alu_fault_monitor;
  import alu_fault_pkg::*;

  localparam int CLK_PERIOD    = 10;
  localparam int RAND_CYCLES   = 400;
  // Reset, the directed tests, policy writes, then random traffic
  localparam int BUDGET_CYCLES = 5 + 20 + 25 + 20 + 20 + 15 + RAND_CYCLES;

  // Two opcodes per class, in sub-unit index order
  localparam alu_op_t OP_TAB [18] = '{
    `ALU_ADD, `ALU_SLL, `ALU_XOR, `ALU_AND, `ALU_BEXT, `ALU_BREV,
    `ALU_FF1, `ALU_CNT, `ALU_SHUF, `ALU_INS, `ALU_LTS, `ALU_NE,
    `ALU_ABS, `ALU_CLIPU, `ALU_MIN, `ALU_MAXU, `ALU_DIV, `ALU_REMU
  };
  localparam alu_op_t OP_UNKNOWN = 7'h7f;

  logic                        clock_gated;
  logic                        rst_n;
  logic [`NUM_ALU-1:0]         alu_enable;
  alu_op_t [`NUM_ALU-1:0]      alu_operator;
  logic [`NUM_ALU-1:0]         error_detected;
  logic                        div_ready;
  logic                        cfg_we;
  cfg_sel_t                    cfg_sel;
  fault_cnt_t                  cfg_data;
  subunit_vec_t [`NUM_ALU-1:0] fault_flags;
  logic [`NUM_ALU-1:0]         perf_fault;

  // Values for the next drive edge
  logic [`NUM_ALU-1:0]         s_en;
  alu_op_t [`NUM_ALU-1:0]      s_op;
  logic [`NUM_ALU-1:0]         s_err;
  logic                        s_div;
  logic                        s_we;
  cfg_sel_t                    s_sel;
  fault_cnt_t                  s_data;

  // Reference model state
  int                          m_cnt [`NUM_ALU][`NUM_SUBUNIT];
  subunit_vec_t                m_flags [`NUM_ALU];
  logic [`NUM_ALU-1:0]         m_set;
  logic [`NUM_ALU-1:0]         m_perf;
  int                          m_thr;
  int                          m_inc;
  int                          m_dec;

  int                          errors;
  int                          checks;
  int                          err_mark;
  logic [31:0]                 rng;

  tb_clock_gen u_clk (
    .clock_gated (clock_gated),
    .rst_n       (rst_n)
  );

  alu_fault_monitor dut (
    .clock_gated      (clock_gated),
    .rst_n            (rst_n),
    .alu_enable_i     (alu_enable),
    .alu_operator_i   (alu_operator),
    .error_detected_i (error_detected),
    .div_ready_i      (div_ready),
    .cfg_we_i         (cfg_we),
    .cfg_sel_i        (cfg_sel),
    .cfg_data_i       (cfg_data),
    .fault_flags_o    (fault_flags),
    .perf_fault_o     (perf_fault)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Class index of an opcode, -1 when unknown
  function automatic int class_of(input alu_op_t op);
    for (int i = 0; i < 18; i++) begin
      if (OP_TAB[i] == op) return i / 2;
    end
    return -1;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model, one rising edge
  //////////////////////////////////////////////////

  task automatic model_edge();
    int c;
    int sum;
    for (int a = 0; a < `NUM_ALU; a++) begin
      c = class_of(s_op[a]);
      m_perf[a] = m_set[a];
      m_set[a]  = 1'b0;
      if (s_en[a] && c < 0) begin
        for (int k = 0; k < `NUM_SUBUNIT; k++) begin
          m_cnt[a][k] = 0;
        end
      end else if (s_en[a] && c >= 0 && !(c == `SU_DIVREM && !s_div) && !m_flags[a][c]) begin
        if (s_err[a]) begin
          sum = m_cnt[a][c] + m_inc;
          if (sum > 255) sum = 255;
          if (sum >= m_thr) begin
            m_flags[a][c] = 1'b1;
            m_set[a]      = 1'b1;
            m_cnt[a][c]   = 0;
          end else begin
            m_cnt[a][c] = sum;
          end
        end else begin
          m_cnt[a][c] = (m_cnt[a][c] > 2) ? m_cnt[a][c] - m_dec : 0;
        end
      end
    end
    // New policy applies from the following edge
    if (s_we) begin
      case (s_sel)
        `CFG_SEL_THRESHOLD: m_thr = s_data;
        `CFG_SEL_INCREASE:  m_inc = s_data % 4;
        `CFG_SEL_DECREASE:  m_dec = s_data % 4;
        default: ;
      endcase
    end
  endtask

  // Drive one cycle, compare outputs with the model, advance the model
  task automatic step();
    @(posedge clock_gated);
    alu_enable     <= s_en;
    alu_operator   <= s_op;
    error_detected <= s_err;
    div_ready      <= s_div;
    cfg_we         <= s_we;
    cfg_sel        <= s_sel;
    cfg_data       <= s_data;
    @(negedge clock_gated);
    for (int a = 0; a < `NUM_ALU; a++) begin
      check_val($sformatf("fault_flags_o[%0d]", a), 64'(fault_flags[a]), 64'(m_flags[a]));
      check_val($sformatf("perf_fault_o[%0d]", a), 64'(perf_fault[a]), 64'(m_perf[a]));
    end
    model_edge();
  endtask

  task automatic op_step(input int alu, input alu_op_t op, input logic err);
    s_en       = '0;
    s_err      = '0;
    s_en[alu]  = 1'b1;
    s_op[alu]  = op;
    s_err[alu] = err;
    step();
  endtask

  task automatic idle_step();
    s_en  = '0;
    s_err = '0;
    step();
  endtask

  task automatic write_policy(input cfg_sel_t sel, input fault_cnt_t data);
    s_en   = '0;
    s_we   = 1'b1;
    s_sel  = sel;
    s_data = data;
    step();
    s_we   = 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("%s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_defaults();
    idle_step();
    check_val("fault_flags_o", 64'(fault_flags), 64'h0);
    check_val("perf_fault_o", 64'(perf_fault), 64'h0);
    repeat (4) op_step(1, `ALU_ADD, 1'b1);
    idle_step();
    // Steps of 2 reach the default threshold of 8 on the fourth error
    check_val("fault_flags_o", 64'(fault_flags), 64'(1) << (`NUM_SUBUNIT + `SU_SHIFT));
    check_val("perf_fault_o", 64'(perf_fault), 64'h0);
    idle_step();
    check_val("perf_fault_o", 64'(perf_fault), 64'b0010);
    idle_step();
    check_val("perf_fault_o", 64'(perf_fault), 64'h0);
    end_test("reset_defaults");
  endtask

  task automatic test_decay_sticky();
    logic [7:0] pattern;
    // Counts 2 4 3 5 4 3 5 7
    pattern = 8'b11001011;
    for (int i = 0; i < 8; i++) begin
      op_step(0, `ALU_XOR, pattern[i]);
    end
    idle_step();
    check_val("fault_flags_o[0]", 64'(fault_flags[0]), 64'h0);
    op_step(0, `ALU_XOR, 1'b1);
    idle_step();
    check_val("fault_flags_o[0]", 64'(fault_flags[0]), 64'(1 << `SU_LOGIC));
    op_step(0, `ALU_XOR, 1'b0);
    op_step(0, `ALU_AND, 1'b1);
    op_step(0, `ALU_AND, 1'b0);
    idle_step();
    check_val("fault_flags_o[0]", 64'(fault_flags[0]), 64'(1 << `SU_LOGIC));
    end_test("decay_sticky");
  endtask

  task automatic test_independence();
    repeat (3) begin
      s_en    = 4'b1101;
      s_err   = 4'b1100;
      s_op[0] = `ALU_LTS;
      s_op[2] = `ALU_CNT;
      s_op[3] = `ALU_MIN;
      step();
    end
    // Unknown opcode drops the count of 6 on ALU 2
    op_step(2, OP_UNKNOWN, 1'b1);
    repeat (3) op_step(2, `ALU_CNT, 1'b1);
    idle_step();
    check_val("fault_flags_o[2]", 64'(fault_flags[2]), 64'h0);
    op_step(3, `ALU_MIN, 1'b1);
    idle_step();
    check_val("fault_flags_o[3]", 64'(fault_flags[3]), 64'(1 << `SU_MINMAX));
    check_val("fault_flags_o[0]", 64'(fault_flags[0]), 64'(1 << `SU_LOGIC));
    end_test("class_alu_independence");
  endtask

  task automatic test_divrem_gating();
    s_div = 1'b0;
    repeat (6) op_step(0, `ALU_DIV, 1'b1);
    idle_step();
    check_val("fault_flags_o[0] divrem", 64'(fault_flags[0][`SU_DIVREM]), 64'h0);
    s_div = 1'b1;
    repeat (3) op_step(0, `ALU_REMU, 1'b1);
    idle_step();
    check_val("fault_flags_o[0] divrem", 64'(fault_flags[0][`SU_DIVREM]), 64'h0);
    op_step(0, `ALU_DIV, 1'b1);
    idle_step();
    check_val("fault_flags_o[0] divrem", 64'(fault_flags[0][`SU_DIVREM]), 64'h1);
    end_test("divrem_gating");
  endtask

  task automatic test_policy_random();
    int idx;
    write_policy(`CFG_SEL_THRESHOLD, 8'd3);
    write_policy(`CFG_SEL_INCREASE, 8'd1);
    write_policy(`CFG_SEL_DECREASE, 8'd1);
    repeat (2) op_step(3, `ALU_SHUF, 1'b1);
    idle_step();
    check_val("fault_flags_o[3] shuffle", 64'(fault_flags[3][`SU_SHUFFLE]), 64'h0);
    op_step(3, `ALU_INS, 1'b1);
    idle_step();
    check_val("fault_flags_o[3] shuffle", 64'(fault_flags[3][`SU_SHUFFLE]), 64'h1);
    for (int i = 0; i < RAND_CYCLES; i++) begin
      for (int a = 0; a < `NUM_ALU; a++) begin
        rng      = xorshift(rng);
        idx      = int'(rng[31:8] % 18);
        s_en[a]  = rng[0];
        s_err[a] = (rng[3:2] == 2'b00);
        s_op[a]  = (rng[7:4] == 4'hf) ? OP_UNKNOWN : OP_TAB[idx];
      end
      rng   = xorshift(rng);
      s_div = rng[1];
      step();
    end
    end_test("policy_random");
  endtask

  initial begin
    errors         = 0;
    checks         = 0;
    err_mark       = 0;
    rng            = 32'd75616;
    alu_enable     = '0;
    alu_operator   = '0;
    error_detected = '0;
    div_ready      = 1'b0;
    cfg_we         = 1'b0;
    cfg_sel        = '0;
    cfg_data       = '0;
    s_en           = '0;
    s_op           = '0;
    s_err          = '0;
    s_div          = 1'b0;
    s_we           = 1'b0;
    s_sel          = '0;
    s_data         = '0;
    for (int a = 0; a < `NUM_ALU; a++) begin
      m_flags[a] = '0;
      for (int k = 0; k < `NUM_SUBUNIT; k++) begin
        m_cnt[a][k] = 0;
      end
    end
    m_set  = '0;
    m_perf = '0;
    m_thr  = `DEF_THRESHOLD;
    m_inc  = `DEF_INCREASE;
    m_dec  = `DEF_DECREASE;

    wait (rst_n === 1'b1);
    test_reset_defaults();
    test_decay_sticky();
    test_independence();
    test_divrem_gating();
    test_policy_random();

    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(BUDGET_CYCLES * CLK_PERIOD + 1000);
    $display("watchdog expired after %0d cycles without the tests completing", BUDGET_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
/*
  Testbench clock and reset source
  10 ns clock, active low reset held for the first few edges
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 5
) (
  output logic clock_gated,
  output logic rst_n
);

  initial begin
    clock_gated = 1'b0;
    forever #(HALF_PERIOD) clock_gated = ~clock_gated;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_gated);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire
